// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= xirq_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== rtl/xirq_arbiter.sv ====
module xirq_arbiter (
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       fire_i,    // some channel pending
    input  logic [4:0] src_nxt_i, // lowest pending channel
    input  logic       src_ack_i, // software acknowledge
    output logic [4:0] src_o,     // captured source
    output logic       cpu_irq_o  // single cycle request
);

    logic       run_q; // interrupt handed to cpu, waiting for ack
    logic [4:0] src_q; // source seen by software
    logic       irq_q; // request pulse

    // --------------------
    // run state
    // --------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            run_q <= 1'b0;
            src_q <= '0;
            irq_q <= 1'b0;
        end else begin
            irq_q <= 1'b0;              // pulse lasts one cycle only
            if (!run_q) begin
                src_q <= src_nxt_i;     // track best candidate while idle
                if (fire_i) begin
                    irq_q <= 1'b1;
                    run_q <= 1'b1;      // hold off until ack
                end
            end else if (src_ack_i) begin
                run_q <= 1'b0;          // next pending may fire one cycle later
            end
        end
    end

    assign src_o     = src_q;
    assign cpu_irq_o = irq_q;

    // never two request cycles back to back
    a_single_pulse: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        cpu_irq_o |=> !cpu_irq_o
    ) else $error("xirq_arbiter: cpu_irq_o high for two cycles");

endmodule

// ==== rtl/xirq_irq_pkg.sv ====
package xirq_irq_pkg;

    // --------------------
    // channel limits
    // --------------------
    localparam int xirq_max_ch_c = 32; // one bit per channel in a bus word

    // --------------------
    // trigger encoding
    // --------------------
    // each channel takes one bit of TRIG_TYPE and one bit of TRIG_POL

    // type bit
    localparam logic xirq_type_level_c = 1'b0; // active while the level holds
    localparam logic xirq_type_edge_c  = 1'b1; // active for one cycle per transition

    // polarity bit
    localparam logic xirq_pol_low_c  = 1'b0; // low level or falling edge
    localparam logic xirq_pol_high_c = 1'b1; // high level or rising edge

    // resulting modes, {type, pol}
    //   00 low level
    //   01 high level
    //   10 falling edge
    //   11 rising edge

endpackage

// ==== rtl/xirq_map_pkg.sv ====
package xirq_map_pkg;

    // --------------------
    // io window
    // --------------------
    localparam logic [31:0] xirq_base_c     = 32'hFFFF_FF80; // block base, word aligned
    localparam int          xirq_win_bits_c = 4;             // 16 byte window

    // register offsets inside the window (byte address, word aligned)
    localparam logic [xirq_win_bits_c-1:0] xirq_enable_off_c  = 4'd0; // r/w channel enable
    localparam logic [xirq_win_bits_c-1:0] xirq_pending_off_c = 4'd4; // r/w pending, write 0 clears
    localparam logic [xirq_win_bits_c-1:0] xirq_source_off_c  = 4'd8; // r source, any write acks
    // offset 12 is unused and reads zero

    // --------------------
    // register data word
    // --------------------
    // the same 32 bits are read either as a channel mask or as a source index

    typedef struct packed {
        logic [26:0] rsvd; // always zero on readback
        logic [4:0]  idx;  // channel number
    } xirq_src_t;

    typedef union packed {
        logic [31:0] mask; // one bit per channel
        xirq_src_t   src;  // source register layout
    } xirq_word_u;

endpackage

// ==== rtl/xirq_pending.sv ====
module xirq_pending #(
    parameter int NUM_CH = 32 // channels in use
) (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic [NUM_CH-1:0] trig_i,    // trigger conditions
    input  logic [NUM_CH-1:0] enable_i,  // channel enable mask
    input  logic [NUM_CH-1:0] clr_n_i,   // 0 bits clear pending
    output logic [NUM_CH-1:0] pending_o, // pending bits for readback
    output logic              fire_o,    // something pending
    output logic [4:0]        src_nxt_o  // lowest pending channel
);

    logic [NUM_CH-1:0] pend_q;  // pending buffer
    logic [4:0]        src_nxt; // encoder result

    // --------------------
    // pending buffer
    // --------------------
    // a trigger sets its bit only while enabled, a bit stays set until cleared
    // a clear in the same cycle as a trigger wins
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pend_q <= '0;
        end else begin
            pend_q <= (pend_q | (trig_i & enable_i)) & clr_n_i;
        end
    end

    // --------------------
    // priority encoder
    // --------------------
    always_comb begin
        src_nxt = '0;
        for (int i = NUM_CH - 1; i >= 0; i--) begin // walk down so index 0 wins
            if (pend_q[i]) begin
                src_nxt = 5'(i);
            end
        end
    end

    assign pending_o = pend_q;
    assign fire_o    = |pend_q;  // any channel waiting
    assign src_nxt_o = src_nxt;

    // a bit may only rise if its channel was enabled in the previous cycle
    a_no_masked_set: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (pend_q & ~$past(pend_q) & ~$past(enable_i)) == '0
    ) else $error("xirq_pending: disabled channel became pending");

endmodule

// ==== rtl/xirq_regs.sv ====
module xirq_regs #(
    parameter int NUM_CH = 32 // channels in use
) (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic [31:0]       addr_i,    // byte address
    input  logic              rden_i,    // read strobe
    input  logic              wren_i,    // write strobe
    input  logic [31:0]       data_i,    // write data
    input  logic [NUM_CH-1:0] pending_i, // pending bits
    input  logic [4:0]        src_i,     // captured source
    output logic [31:0]       data_o,    // read data, zero when idle
    output logic              ack_o,     // one cycle after the strobe
    output logic [NUM_CH-1:0] enable_o,  // channel enable mask
    output logic [NUM_CH-1:0] clr_n_o,   // one cycle clear mask
    output logic              src_ack_o  // write to source register
);
    import xirq_map_pkg::*;

    logic                       acc_en;  // address inside the window
    logic                       rd_en;
    logic                       wr_en;
    logic [xirq_win_bits_c-1:0] offs;    // word aligned offset
    xirq_word_u                 wr_word; // write data view
    xirq_word_u                 rd_word; // read data view
    logic [NUM_CH-1:0]          enable_q;
    logic [NUM_CH-1:0]          clr_n_q;
    logic [31:0]                data_q;
    logic                       ack_q;

    // --------------------
    // address decode
    // --------------------
    assign acc_en = (addr_i[31:xirq_win_bits_c] == xirq_base_c[31:xirq_win_bits_c]);
    assign offs   = {addr_i[xirq_win_bits_c-1:2], 2'b00}; // byte lanes ignored
    assign rd_en  = acc_en & rden_i;
    assign wr_en  = acc_en & wren_i;

    assign wr_word   = data_i;
    assign src_ack_o = wr_en & (offs == xirq_source_off_c); // any write acks

    // --------------------
    // write side
    // --------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            enable_q <= '0;
            clr_n_q  <= '1;
        end else begin
            clr_n_q <= '1;                                   // no clear by default
            if (wr_en && (offs == xirq_enable_off_c)) begin
                enable_q <= wr_word.mask[NUM_CH-1:0];
            end
            if (wr_en && (offs == xirq_pending_off_c)) begin
                clr_n_q <= wr_word.mask[NUM_CH-1:0];         // zero bits clear
            end
        end
    end

    // --------------------
    // read side
    // --------------------
    always_comb begin
        rd_word = '0;
        case (offs)
            xirq_enable_off_c:  rd_word.mask[NUM_CH-1:0] = enable_q;
            xirq_pending_off_c: rd_word.mask[NUM_CH-1:0] = pending_i;
            xirq_source_off_c:  rd_word.src.idx          = src_i;
            default:            rd_word                  = '0; // offset 12
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ack_q  <= 1'b0;
            data_q <= '0;
        end else begin
            ack_q  <= rd_en | wr_en;          // every window access accepted
            data_q <= rd_en ? rd_word : '0;   // bus stays zero otherwise
        end
    end

    assign data_o   = data_q;
    assign ack_o    = ack_q;
    assign enable_o = enable_q;
    assign clr_n_o  = clr_n_q;

    // ack only follows a strobe that hit the window
    a_ack_in_window: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        ack_o |-> $past((rden_i | wren_i) &&
                        (addr_i[31:xirq_win_bits_c] == xirq_base_c[31:xirq_win_bits_c]))
    ) else $error("xirq_regs: ack without in-window strobe");

endmodule

// ==== rtl/xirq_top.sv ====
module xirq_top #(
    parameter int          NUM_CH    = xirq_irq_pkg::xirq_max_ch_c, // channels in use
    parameter logic [31:0] TRIG_TYPE = '0,                           // 0 level, 1 edge
    parameter logic [31:0] TRIG_POL  = '0                            // 0 low/fall, 1 high/rise
) (
    input  logic        clk_i,
    input  logic        rstn_i,
    // host bus
    input  logic [31:0] addr_i,
    input  logic        rden_i,
    input  logic        wren_i,
    input  logic [31:0] data_i,
    output logic [31:0] data_o,
    output logic        ack_o,
    // external lines
    input  logic [31:0] xirq_i,
    // cpu request
    output logic        cpu_irq_o
);

    logic [NUM_CH-1:0] trig;    // trigger conditions
    logic [NUM_CH-1:0] enable;  // enable mask
    logic [NUM_CH-1:0] clr_n;   // clear mask
    logic [NUM_CH-1:0] pending; // pending bits
    logic              fire;
    logic [4:0]        src_nxt;
    logic [4:0]        src;
    logic              src_ack;

    // --------------------
    // register block
    // --------------------
    xirq_regs #(
        .NUM_CH(NUM_CH)
    ) u_regs (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .addr_i   (addr_i),
        .rden_i   (rden_i),
        .wren_i   (wren_i),
        .data_i   (data_i),
        .pending_i(pending),
        .src_i    (src),
        .data_o   (data_o),
        .ack_o    (ack_o),
        .enable_o (enable),
        .clr_n_o  (clr_n),
        .src_ack_o(src_ack)
    );

    // --------------------
    // interrupt path
    // --------------------
    xirq_trigger #(
        .NUM_CH   (NUM_CH),
        .TRIG_TYPE(TRIG_TYPE),
        .TRIG_POL (TRIG_POL)
    ) u_trigger (
        .clk_i (clk_i),
        .rstn_i(rstn_i),
        .xirq_i(xirq_i),
        .trig_o(trig)
    );

    xirq_pending #(
        .NUM_CH(NUM_CH)
    ) u_pending (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .trig_i   (trig),
        .enable_i (enable),
        .clr_n_i  (clr_n),
        .pending_o(pending),
        .fire_o   (fire),
        .src_nxt_o(src_nxt)
    );

    xirq_arbiter u_arbiter (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .fire_i   (fire),
        .src_nxt_i(src_nxt),
        .src_ack_i(src_ack),
        .src_o    (src),
        .cpu_irq_o(cpu_irq_o)
    );

endmodule

// ==== rtl/xirq_trigger.sv ====
module xirq_trigger #(
    parameter int          NUM_CH    = xirq_irq_pkg::xirq_max_ch_c, // channels in use
    parameter logic [31:0] TRIG_TYPE = '0,                           // 0 level, 1 edge
    parameter logic [31:0] TRIG_POL  = '0                            // 0 low/fall, 1 high/rise
) (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic [31:0]       xirq_i, // raw external lines
    output logic [NUM_CH-1:0] trig_o  // per channel trigger condition
);
    import xirq_irq_pkg::*;

    // {type, pol} selectors
    localparam logic [1:0] mode_lvl_low_c  = {xirq_type_level_c, xirq_pol_low_c};
    localparam logic [1:0] mode_lvl_high_c = {xirq_type_level_c, xirq_pol_high_c};
    localparam logic [1:0] mode_edg_fall_c = {xirq_type_edge_c, xirq_pol_low_c};
    localparam logic [1:0] mode_edg_rise_c = {xirq_type_edge_c, xirq_pol_high_c};

    logic [NUM_CH-1:0] sync1_q; // first stage, trigger is evaluated here
    logic [NUM_CH-1:0] sync2_q; // second stage, previous value for edges

    if ((NUM_CH < 1) || (NUM_CH > xirq_max_ch_c)) begin : g_num_ch_chk
        $error("xirq_trigger: NUM_CH must be 1..%0d", xirq_max_ch_c);
    end

    // --------------------
    // synchroniser
    // --------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
        end else begin
            sync1_q <= xirq_i[NUM_CH-1:0]; // unused upper lines dropped
            sync2_q <= sync1_q;
        end
    end

    // --------------------
    // trigger select
    // --------------------
    always_comb begin
        for (int i = 0; i < NUM_CH; i++) begin
            unique case ({TRIG_TYPE[i], TRIG_POL[i]})
                mode_lvl_low_c:  trig_o[i] = ~sync1_q[i];
                mode_lvl_high_c: trig_o[i] = sync1_q[i];
                mode_edg_fall_c: trig_o[i] = ~sync1_q[i] & sync2_q[i];  // 1 -> 0
                mode_edg_rise_c: trig_o[i] = sync1_q[i] & ~sync2_q[i];  // 0 -> 1
                default:         trig_o[i] = 1'b0;
            endcase
        end
    end

endmodule

// ==== include/xirq_tb_ref.svh ====
`ifndef XIRQ_TB_REF_SVH
`define XIRQ_TB_REF_SVH

// --------------------
// trigger model
// --------------------
// cur is the first synchroniser stage, prev the second one
function automatic logic ref_trig(
    input logic typ,  // type bit of the channel
    input logic pol,  // polarity bit of the channel
    input logic cur,
    input logic prev
);
    logic res;
    res = 1'b0;
    case ({typ, pol})
        {xirq_irq_pkg::xirq_type_level_c, xirq_irq_pkg::xirq_pol_low_c}:
            res = ~cur;
        {xirq_irq_pkg::xirq_type_level_c, xirq_irq_pkg::xirq_pol_high_c}:
            res = cur;
        {xirq_irq_pkg::xirq_type_edge_c, xirq_irq_pkg::xirq_pol_low_c}:
            res = ~cur & prev;   // falling
        {xirq_irq_pkg::xirq_type_edge_c, xirq_irq_pkg::xirq_pol_high_c}:
            res = cur & ~prev;   // rising
        default:
            res = 1'b0;
    endcase
    return res;
endfunction

// --------------------
// priority model
// --------------------
// lowest set bit wins, empty mask gives 0
function automatic logic [4:0] ref_src(
    input logic [31:0] mask
);
    logic [4:0] idx;
    idx = '0;
    for (int i = 31; i >= 0; i--) begin
        if (mask[i]) begin
            idx = 5'(i);
        end
    end
    return idx;
endfunction

`endif

// ==== verification/xirq_tb.sv ====
module xirq_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import xirq_map_pkg::*;

    `include "xirq_tb_ref.svh"

    localparam int          NUM_CH    = 8;
    localparam logic [31:0] TRIG_TYPE = 32'h0000_006C; // edges on 2,3,5,6
    localparam logic [31:0] TRIG_POL  = 32'h0000_0035; // high/rise on 0,2,4,5
    localparam logic [31:0] IDLE      = 32'h0000_00CA; // no trigger active on any line
    localparam int          TMO       = 100;           // cycles per wait

    logic        clk_i;
    logic        rstn_i;
    logic [31:0] addr_i;
    logic        rden_i;
    logic        wren_i;
    logic [31:0] data_i;
    logic [31:0] xirq_i;
    logic [31:0] data_o;
    logic        ack_o;
    logic        cpu_irq_o;

    int          err_cnt = 0; // value mismatches
    int          tmo_cnt = 0; // waits that ran out
    int          irq_cnt = 0; // cpu pulses seen
    integer      seed;

    xirq_top #(
        .NUM_CH   (NUM_CH),
        .TRIG_TYPE(TRIG_TYPE),
        .TRIG_POL (TRIG_POL)
    ) DUT (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .addr_i   (addr_i),
        .rden_i   (rden_i),
        .wren_i   (wren_i),
        .data_i   (data_i),
        .data_o   (data_o),
        .ack_o    (ack_o),
        .xirq_i   (xirq_i),
        .cpu_irq_o(cpu_irq_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i; // 4 ns period
    end

    // --------------------
    // reference model
    // --------------------
    logic [NUM_CH-1:0] s1_m, s2_m, pend_m, en_m, clr_m;
    logic              run_m, irq_m, ack_m;
    logic [4:0]        src_m;
    xirq_word_u        data_m;

    always @(posedge clk_i or negedge rstn_i) begin : ref_model
        logic [NUM_CH-1:0] trig;
        logic [NUM_CH-1:0] pend_old;
        logic              in_win;
        logic [3:0]        offs;
        xirq_word_u        rd;
        if (!rstn_i) begin
            s1_m   = '0;
            s2_m   = '0;
            pend_m = '0;
            en_m   = '0;
            clr_m  = '1;
            run_m  = 1'b0;
            irq_m  = 1'b0;
            ack_m  = 1'b0;
            src_m  = '0;
            data_m = '0;
        end else begin
            pend_old = pend_m;
            for (int i = 0; i < NUM_CH; i++) begin
                trig[i] = ref_trig(TRIG_TYPE[i], TRIG_POL[i], s1_m[i], s2_m[i]);
            end
            in_win = (addr_i[31:4] == xirq_base_c[31:4]);
            offs   = {addr_i[3:2], 2'b00};
            rd     = '0;
            if (offs == xirq_enable_off_c) rd.mask[NUM_CH-1:0] = en_m;
            if (offs == xirq_pending_off_c) rd.mask[NUM_CH-1:0] = pend_old;
            if (offs == xirq_source_off_c) rd.src.idx = src_m;
            ack_m  = in_win & (rden_i | wren_i);
            data_m = (in_win && rden_i) ? rd : '0;
            irq_m  = 1'b0;
            if (!run_m) begin
                src_m = ref_src({{(32-NUM_CH){1'b0}}, pend_old}); // follows best while idle
                if (|pend_old) begin
                    irq_m = 1'b1;
                    run_m = 1'b1;
                end
            end else if (in_win && wren_i && offs == xirq_source_off_c) begin
                run_m = 1'b0;
            end
            pend_m = (pend_m | (trig & en_m)) & clr_m; // clear from last cycle wins
            clr_m  = '1;
            if (in_win && wren_i && offs == xirq_pending_off_c) clr_m = data_i[NUM_CH-1:0];
            if (in_win && wren_i && offs == xirq_enable_off_c) en_m = data_i[NUM_CH-1:0];
            s2_m = s1_m;
            s1_m = xirq_i[NUM_CH-1:0];
        end
    end

    // --------------------
    // compare tasks
    // --------------------
    task automatic check_word(input string name, input xirq_word_u exp, input xirq_word_u act);
        if (act !== exp) begin
            err_cnt++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            err_cnt++;
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    function automatic xirq_word_u src_word(input logic [4:0] idx);
        xirq_word_u w;
        w = '0;
        w.src.idx = idx;
        return w;
    endfunction

    always @(negedge clk_i) begin : compare
        if (rstn_i) begin
            check_bit("ack_o", ack_m, ack_o);
            check_bit("cpu_irq_o", irq_m, cpu_irq_o);
            check_word("data_o", data_m, data_o);
        end
    end

    always @(posedge clk_i) begin
        if (cpu_irq_o) irq_cnt++; // value from the previous cycle
    end

    // --------------------
    // bus and wait tasks
    // --------------------
    task automatic bus_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                              input int limit, output xirq_word_u rdata, output logic got_ack);
        got_ack = 1'b0;
        rdata   = '0;
        addr_i  = addr;
        data_i  = wdata;
        wren_i  = wr;
        rden_i  = ~wr;
        for (int n = 0; n < limit && !got_ack; n++) begin
            @(negedge clk_i);
            if (ack_o) begin
                got_ack = 1'b1;
                rdata   = data_o;
            end
        end
        wren_i = 1'b0; // strobe gone before the next edge
        rden_i = 1'b0;
        addr_i = '0;
        data_i = '0;
    endtask

    task automatic bus_write(input logic [3:0] offs, input logic [31:0] wdata);
        xirq_word_u d;
        logic       ok;
        bus_access(1'b1, xirq_base_c + offs, wdata, TMO, d, ok);
        if (!ok) begin
            tmo_cnt++;
            $display("timeout: no ack for write to offset %0d", offs);
        end
    endtask

    task automatic bus_read(input logic [3:0] offs, output xirq_word_u rdata);
        logic ok;
        bus_access(1'b0, xirq_base_c + offs, '0, TMO, rdata, ok);
        if (!ok) begin
            tmo_cnt++;
            $display("timeout: no ack for read from offset %0d", offs);
        end
    endtask

    task automatic wait_irq(input string name, input int base);
        for (int n = 0; n < TMO && irq_cnt <= base; n++) begin
            @(negedge clk_i);
        end
        if (irq_cnt <= base) begin
            tmo_cnt++;
            $display("timeout in %s: no interrupt pulse from DUT", name);
        end
    endtask

    task automatic clear_all();
        xirq_i = IDLE;
        repeat (4) @(negedge clk_i);
        bus_write(xirq_pending_off_c, 32'h0);
        bus_write(xirq_source_off_c, 32'h0); // ack whatever is running
        repeat (4) @(negedge clk_i);
    endtask

    // --------------------
    // stimulus
    // --------------------
    initial begin : main
        xirq_word_u rd;
        xirq_word_u pend;
        logic       ok;
        int         base;
        logic [7:0] en_r;
        seed   = 32'h924a271a;
        rstn_i = 1'b0;
        addr_i = '0;
        rden_i = 1'b0;
        wren_i = 1'b0;
        data_i = '0;
        xirq_i = IDLE;
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;
        repeat (3) @(negedge clk_i);

        // registers
        bus_write(xirq_enable_off_c, 32'hFFFF_FFFF);
        bus_read(xirq_enable_off_c, rd);
        check_word("enable readback", 32'h0000_00FF, rd); // masked to 8 channels
        bus_write(xirq_enable_off_c, 32'h0);
        bus_read(4'd12, rd);
        check_word("offset 12", 32'h0, rd);
        bus_access(1'b0, xirq_base_c + 32'h10, '0, 20, rd, ok); // just past the window
        check_bit("no ack outside window", 1'b0, ok);

        // level triggers on 0 and 1
        bus_write(xirq_enable_off_c, 32'h3);
        base   = irq_cnt;
        xirq_i = IDLE | 32'h1;
        wait_irq("level high", base);
        bus_read(xirq_source_off_c, rd);
        check_word("level high source", src_word(5'd0), rd);
        bus_read(xirq_pending_off_c, rd);
        check_bit("level high pending", 1'b1, rd.mask[0]);
        bus_write(xirq_pending_off_c, ~32'h1);
        repeat (3) @(negedge clk_i);
        bus_read(xirq_pending_off_c, rd);
        check_bit("level re-set after clear", 1'b1, rd.mask[0]);
        clear_all();
        base   = irq_cnt;
        xirq_i = IDLE & ~32'h2;
        wait_irq("level low", base);
        bus_read(xirq_source_off_c, rd);
        check_word("level low source", src_word(5'd1), rd);
        bus_read(xirq_pending_off_c, rd);
        check_bit("level low pending", 1'b1, rd.mask[1]);
        clear_all();

        // edge triggers on 2 and 3
        bus_write(xirq_enable_off_c, 32'hC);
        base   = irq_cnt;
        xirq_i = IDLE | 32'h4;
        wait_irq("rising edge", base);
        bus_read(xirq_source_off_c, rd);
        check_word("rising source", src_word(5'd2), rd);
        bus_read(xirq_pending_off_c, rd);
        check_bit("rising pending", 1'b1, rd.mask[2]);
        bus_write(xirq_pending_off_c, ~32'h4);
        repeat (5) @(negedge clk_i);
        bus_read(xirq_pending_off_c, rd);
        check_bit("rising stays clear", 1'b0, rd.mask[2]);
        bus_write(xirq_source_off_c, 32'h0);
        base   = irq_cnt;
        xirq_i = (IDLE | 32'h4) & ~32'h8;
        wait_irq("falling edge", base);
        bus_read(xirq_source_off_c, rd);
        check_word("falling source", src_word(5'd3), rd);
        bus_write(xirq_pending_off_c, ~32'h8);
        repeat (5) @(negedge clk_i);
        bus_read(xirq_pending_off_c, rd);
        check_bit("falling stays clear", 1'b0, rd.mask[3]);
        clear_all();

        // priority and acknowledge, 4 level high and 5 rising
        bus_write(xirq_enable_off_c, 32'h30);
        base   = irq_cnt;
        xirq_i = IDLE | 32'h30;
        wait_irq("priority first", base);
        bus_read(xirq_pending_off_c, pend);
        check_word("priority pending", 32'h30, pend); // both channels latched
        bus_read(xirq_source_off_c, rd);
        check_word("priority source", src_word(ref_src(32'h30)), rd);
        repeat (10) @(negedge clk_i);
        check_bit("single pulse before ack", 1'b1, irq_cnt == base + 1);
        xirq_i = IDLE | 32'h20; // release the level, edge 5 stays high
        repeat (3) @(negedge clk_i);
        bus_write(xirq_pending_off_c, ~32'h10);
        base = irq_cnt;
        bus_write(xirq_source_off_c, 32'h0);
        wait_irq("priority second", base);
        bus_read(xirq_source_off_c, rd);
        check_word("second source", src_word(5'd5), rd);
        clear_all();

        // random toggles with a random enable subset
        en_r = 8'($random(seed));
        bus_write(xirq_enable_off_c, {24'h0, en_r});
        for (int n = 0; n < 200; n++) begin
            xirq_i = $random(seed);
            @(negedge clk_i);
        end
        xirq_i = IDLE;
        repeat (4) @(negedge clk_i);
        bus_read(xirq_pending_off_c, rd); // model compares the data word
        check_word("random disabled channels", 32'h0, rd.mask & ~{24'h0, en_r});
        clear_all();
        bus_write(xirq_enable_off_c, 32'h0);
        repeat (5) @(negedge clk_i);

        // ----- report -----
        $display("errors: %0d mismatches, %0d timeouts", err_cnt, tmo_cnt);
        if (err_cnt == 0 && tmo_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
rtl/xirq_map_pkg.sv
rtl/xirq_irq_pkg.sv
rtl/xirq_trigger.sv
rtl/xirq_pending.sv
rtl/xirq_arbiter.sv
rtl/xirq_regs.sv
rtl/xirq_top.sv
verification/xirq_tb.sv
